/* test/llc_stimulus.txt */
// cmd a1 a2 a3 a4 a5 a6, hex. 0 desc: desc chan(1 miss) way refill evict etag
// 1 unlock: set way, 2 count-down: id n, 3 way enable: mask, 4 credit: chan n
// 5 drain, 6 hold: cycles pending, f end
0 0123 1 1 1 0 00
5 0 0 0 0 0 00
1 3 1 0 0 0 00
2 0 1 0 0 0 00
// same tag hits on the hit channel
0 0123 0 1 0 0 00
5 0 0 0 0 0 00
1 3 1 0 0 0 00
// fill set 5 with dirty lines
4 1 2 0 0 0 00
0 5a05 1 1 1 0 00
0 6a15 1 2 1 0 00
0 5a25 1 4 1 0 00
4 1 1 0 0 0 00
0 6a35 1 8 1 0 00
4 1 1 0 0 0 00
// write miss waits on the locked victim, then evicts it
0 7b05 1 1 1 1 a0
6 4 1 0 0 0 00
1 5 1 0 0 0 00
5 0 0 0 0 0 00
// flush of a dirty line waits for a miss credit
1 5 2 0 0 0 00
0 8250 1 2 0 1 a1
6 4 1 0 0 0 00
4 1 1 0 0 0 00
5 0 0 0 0 0 00
// flushed line misses again
4 1 2 0 0 0 00
0 0a15 1 2 1 0 00
5 0 0 0 0 0 00
// hit behind an outstanding miss of the same id
0 0123 1 1 0 0 00
5 0 0 0 0 0 00
2 0 2 0 0 0 00
1 3 1 0 0 0 00
0 0123 0 1 0 0 00
5 0 0 0 0 0 00
// way 0 disabled, its tag misses into way 1
3 e 0 0 0 0 00
4 1 1 0 0 0 00
0 0123 1 2 1 0 00
5 0 0 0 0 0 00
f 0 0 0 0 0 00

/* sources.f */
+incdir+rtl
rtl/llc_desc_pkg.sv
rtl/llc_store_pkg.sv
rtl/llc_tag_if.sv
rtl/llc_way_cfg.sv
rtl/llc_tag_store.sv
rtl/llc_lock_table.sv
rtl/llc_miss_counters.sv
rtl/llc_hit_miss.sv
test/tb_llc_hit_miss.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_llc_hit_miss
FILELIST  = sources.f
LOG       = sim.log
PASS_MSG  = >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* test/tb_llc_hit_miss.sv */
`timescale 1ns/1ps
`default_nettype none
`include "llc_defs.svh"

module tb_llc_hit_miss;

  localparam int RST_CYCLES   = 4;
  localparam int MAX_LINES    = 64;
  localparam int COLS         = 7;
  localparam int CYC_PER_LINE = 40;

  // command codes, first column of the stimulus file
  localparam logic [15:0] CMD_DESC   = 16'h0;
  localparam logic [15:0] CMD_UNLOCK = 16'h1;
  localparam logic [15:0] CMD_DOWN   = 16'h2;
  localparam logic [15:0] CMD_CFG    = 16'h3;
  localparam logic [15:0] CMD_CREDIT = 16'h4;
  localparam logic [15:0] CMD_DRAIN  = 16'h5;
  localparam logic [15:0] CMD_HOLD   = 16'h6;
  localparam logic [15:0] CMD_END    = 16'hf;

  // one output still owed by the DUT
  typedef struct packed {
    logic        miss_chan;
    logic [15:0] desc;
    logic [3:0]  way;
    logic        refill;
    logic        evict;
    logic [7:0]  etag;
  } exp_t;

  logic                    clk_i;
  logic                    rst_i;
  logic                    valid_i;
  logic                    ready_o;
  logic [15:0]             desc_i;
  logic                    hit_valid_o;
  logic                    hit_credit_i;
  logic                    miss_valid_o;
  logic                    miss_credit_i;
  logic [`LLC_ID_W-1:0]    out_id_o;
  logic                    out_rw_o;
  logic                    out_flush_o;
  logic [`LLC_INDEX_W-1:0] out_index_o;
  logic [`LLC_TAG_W-1:0]   out_tag_o;
  logic [`LLC_WAYS-1:0]    out_way_o;
  logic                    refill_o;
  logic                    evict_o;
  logic [`LLC_TAG_W-1:0]   evict_tag_o;
  logic                    unlock_valid_i;
  logic [`LLC_INDEX_W-1:0] unlock_index_i;
  logic [`LLC_WAYS-1:0]    unlock_way_i;
  logic                    cnt_down_valid_i;
  logic [`LLC_ID_W-1:0]    cnt_down_id_i;
  logic                    cfg_we_i;
  logic [`LLC_WAYS-1:0]    cfg_way_en_i;

  logic [15:0] stim_mem [0:MAX_LINES*COLS-1];
  exp_t        exp_q [$];
  int          value_errs;
  int          other_errs;
  int          cycle_cnt;
  int          cycle_limit;
  // credit model per channel
  int          hit_cred;
  int          miss_cred;

  llc_hit_miss dut0 (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .valid_i          ( valid_i          ),
    .ready_o          ( ready_o          ),
    .desc_i           ( desc_i           ),
    .hit_valid_o      ( hit_valid_o      ),
    .hit_credit_i     ( hit_credit_i     ),
    .miss_valid_o     ( miss_valid_o     ),
    .miss_credit_i    ( miss_credit_i    ),
    .out_id_o         ( out_id_o         ),
    .out_rw_o         ( out_rw_o         ),
    .out_flush_o      ( out_flush_o      ),
    .out_index_o      ( out_index_o      ),
    .out_tag_o        ( out_tag_o        ),
    .out_way_o        ( out_way_o        ),
    .refill_o         ( refill_o         ),
    .evict_o          ( evict_o          ),
    .evict_tag_o      ( evict_tag_o      ),
    .unlock_valid_i   ( unlock_valid_i   ),
    .unlock_index_i   ( unlock_index_i   ),
    .unlock_way_i     ( unlock_way_i     ),
    .cnt_down_valid_i ( cnt_down_valid_i ),
    .cnt_down_id_i    ( cnt_down_id_i    ),
    .cfg_we_i         ( cfg_we_i         ),
    .cfg_way_en_i     ( cfg_way_en_i     )
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // checking helpers
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] want);
    assert (got === want) else begin
      $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
      value_errs++;
    end
  endtask

  task automatic check_quiet();
    check_val("ready_o", 16'(ready_o), 16'h0);
    check_val("hit_valid_o", 16'(hit_valid_o), 16'h0);
    check_val("miss_valid_o", 16'(miss_valid_o), 16'h0);
  endtask

  // fields follow the descriptor layout: flush, rw, id, then the 12 bit word
  task automatic check_output();
    exp_t       e;
    logic [3:0] want_index;
    if (exp_q.size() == 0) begin
      $display("output pulse at %0t with no descriptor outstanding", $time);
      other_errs++;
    end else begin
      e = exp_q.pop_front();
      // flush keeps its set index one nibble higher
      want_index = e.desc[15] ? e.desc[7:4] : e.desc[3:0];
      check_val("miss_valid_o", 16'(miss_valid_o), 16'(e.miss_chan));
      check_val("hit_valid_o", 16'(hit_valid_o), 16'(!e.miss_chan));
      check_val("out_flush_o", 16'(out_flush_o), 16'(e.desc[15]));
      check_val("out_rw_o", 16'(out_rw_o), 16'(e.desc[14]));
      check_val("out_id_o", 16'(out_id_o), 16'(e.desc[13:12]));
      check_val("out_index_o", 16'(out_index_o), 16'(want_index));
      if (!e.desc[15]) check_val("out_tag_o", 16'(out_tag_o), 16'(e.desc[11:4]));
      check_val("out_way_o", 16'(out_way_o), 16'(e.way));
      check_val("refill_o", 16'(refill_o), 16'(e.refill));
      check_val("evict_o", 16'(evict_o), 16'(e.evict));
      // evict tag only means something with evict set
      if (e.evict) check_val("evict_tag_o", 16'(evict_tag_o), 16'(e.etag));
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks, each starts and ends 1 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////
  task automatic send_desc(input int base);
    exp_t e;
    e.desc      = stim_mem[base+1];
    e.miss_chan = stim_mem[base+2][0];
    e.way       = stim_mem[base+3][3:0];
    e.refill    = stim_mem[base+4][0];
    e.evict     = stim_mem[base+5][0];
    e.etag      = stim_mem[base+6][7:0];
    while (!ready_o) begin
      @(posedge clk_i);
      #1;
    end
    exp_q.push_back(e);
    valid_i = 1'b1;
    desc_i  = e.desc;
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
  endtask

  task automatic pulse_unlock(input logic [3:0] index, input logic [3:0] way);
    unlock_valid_i = 1'b1;
    unlock_index_i = index;
    unlock_way_i   = way;
    @(posedge clk_i);
    #1;
    unlock_valid_i = 1'b0;
  endtask

  // one count-down per cycle for n cycles
  task automatic pulse_count_down(input logic [1:0] id, input int n);
    cnt_down_valid_i = 1'b1;
    cnt_down_id_i    = id;
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
    cnt_down_valid_i = 1'b0;
  endtask

  task automatic write_way_en(input logic [3:0] mask);
    cfg_we_i     = 1'b1;
    cfg_way_en_i = mask;
    @(posedge clk_i);
    #1;
    cfg_we_i = 1'b0;
  endtask

  // chan 0 hit, 1 miss
  task automatic return_credits(input logic chan, input int n);
    if (chan) miss_credit_i = 1'b1;
    else hit_credit_i = 1'b1;
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
    hit_credit_i  = 1'b0;
    miss_credit_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_held(input int cycles, input int pending);
    repeat (cycles) begin
      @(posedge clk_i);
      #1;
    end
    assert (exp_q.size() == pending) else begin
      $display("descriptor not held back at %0t: %0d outputs outstanding, %0d expected",
               $time, exp_q.size(), pending);
      other_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor and credit model
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (!rst_i) begin
      assert (!(hit_valid_o && miss_valid_o)) else begin
        $display("both channels fired in the same cycle at %0t", $time);
        other_errs++;
      end
      if (hit_valid_o || miss_valid_o) check_output();
      if (hit_valid_o) begin
        assert (hit_cred > 0) else begin
          $display("hit channel fired without a credit at %0t", $time);
          other_errs++;
        end
      end
      if (miss_valid_o) begin
        assert (miss_cred > 0) else begin
          $display("miss channel fired without a credit at %0t", $time);
          other_errs++;
        end
      end
      hit_cred  = hit_cred + int'(hit_credit_i) - int'(hit_valid_o);
      miss_cred = miss_cred + int'(miss_credit_i) - int'(miss_valid_o);
    end
  end

  // run limit grows with the stimulus length
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout after %0d cycles, stimulus did not complete", cycle_cnt);
      other_errs++;
      finish_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int unsigned seed;
    int          n_lines;
    int          base;
    logic [15:0] cmd;
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    valid_i          = 1'b0;
    desc_i           = '0;
    hit_credit_i     = 1'b0;
    miss_credit_i    = 1'b0;
    unlock_valid_i   = 1'b0;
    unlock_index_i   = '0;
    unlock_way_i     = '0;
    cnt_down_valid_i = 1'b0;
    cnt_down_id_i    = '0;
    cfg_we_i         = 1'b0;
    cfg_way_en_i     = '0;
    value_errs       = 0;
    other_errs       = 0;
    cycle_cnt        = 0;
    hit_cred         = `LLC_CREDITS;
    miss_cred        = `LLC_CREDITS;
    seed             = $urandom(98);

    $readmemh("test/llc_stimulus.txt", stim_mem);
    n_lines = 0;
    while (n_lines < MAX_LINES && stim_mem[n_lines*COLS] != CMD_END) n_lines++;
    if (n_lines == MAX_LINES) begin
      $display("stimulus file has no end line");
      other_errs++;
    end
    cycle_limit = CYC_PER_LINE * n_lines + `LLC_SETS + RST_CYCLES;

    // outputs quiet during reset
    @(posedge clk_i);
    for (int i = 1; i < RST_CYCLES; i++) begin
      @(negedge clk_i);
      check_quiet();
      @(posedge clk_i);
    end
    #1;
    rst_i = 1'b0;

    // tag clear walk, one set per cycle
    repeat (`LLC_SETS) begin
      @(negedge clk_i);
      check_quiet();
    end
    @(negedge clk_i);
    check_val("ready_o", 16'(ready_o), 16'h1);
    @(posedge clk_i);
    #1;

    for (int i = 0; i < n_lines; i++) begin
      base = i * COLS;
      cmd  = stim_mem[base];
      // idle gap jitter
      repeat ($urandom % 3) begin
        @(posedge clk_i);
        #1;
      end
      case (cmd)
        CMD_DESC:   send_desc(base);
        CMD_UNLOCK: pulse_unlock(stim_mem[base+1][3:0], stim_mem[base+2][3:0]);
        CMD_DOWN:   pulse_count_down(stim_mem[base+1][1:0], int'(stim_mem[base+2]));
        CMD_CFG:    write_way_en(stim_mem[base+1][3:0]);
        CMD_CREDIT: return_credits(stim_mem[base+1][0], int'(stim_mem[base+2]));
        CMD_DRAIN:  wait_drained();
        CMD_HOLD:   check_held(int'(stim_mem[base+1]), int'(stim_mem[base+2]));
        default: begin
          $display("unknown stimulus command %h on line %0d", cmd, i);
          other_errs++;
        end
      endcase
    end

    wait_drained();
    repeat (2) begin
      @(posedge clk_i);
      #1;
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* rtl/llc_hit_miss.sv */
`timescale 1ns/1ps
`default_nettype none
`include "llc_defs.svh"

module llc_hit_miss (
  input  logic                   clk_i,
  input  logic                   rst_i,
  // descriptor input
  input  logic                   valid_i,
  output logic                   ready_o,
  input  llc_desc_pkg::desc_t    desc_i,
  // output channels
  output logic                   hit_valid_o,
  input  logic                   hit_credit_i,
  output logic                   miss_valid_o,
  input  logic                   miss_credit_i,
  output llc_desc_pkg::id_t      out_id_o,
  output logic                   out_rw_o,
  output logic                   out_flush_o,
  output llc_desc_pkg::index_t   out_index_o,
  output llc_desc_pkg::tag_t     out_tag_o,
  output llc_desc_pkg::way_ind_t out_way_o,
  output logic                   refill_o,
  output logic                   evict_o,
  output llc_desc_pkg::tag_t     evict_tag_o,
  // unlock from downstream
  input  logic                   unlock_valid_i,
  input  llc_desc_pkg::index_t   unlock_index_i,
  input  llc_desc_pkg::way_ind_t unlock_way_i,
  // miss retirement
  input  logic                   cnt_down_valid_i,
  input  llc_desc_pkg::id_t      cnt_down_id_i,
  // way enable config
  input  logic                   cfg_we_i,
  input  llc_desc_pkg::way_ind_t cfg_way_en_i
);
  import llc_desc_pkg::*;
  import llc_store_pkg::*;

  localparam int CRED_W = $clog2(`LLC_CREDITS + 1);

  llc_tag_if tag_if ();

  way_ind_t          way_en;
  logic              held_q;
  desc_t             desc_q;
  store_res_t        res_q, res_cur;
  logic              accept, is_flush, to_hit, blocked, cred_avail, send;
  logic              locked, lock_req, to_miss, stall, cnt_up;
  // index 0 hit channel, index 1 miss channel
  logic [CRED_W-1:0] cred_q [2];
  logic [1:0]        cred_ret, cred_spend;

  // set index sits in a different field for each view of the word
  function automatic index_t desc_index(input desc_t d);
    return d.flush ? d.word.flush.index : d.word.lookup.index;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // input side and tag store request
  ////////////////////////////////////////////////////////////////////////////
  // one descriptor at a time, none during the clear walk
  assign ready_o = ~held_q & tag_if.req_ready;
  assign accept  = valid_i & ready_o;

  assign tag_if.req_valid = valid_i & ~held_q;
  assign tag_if.mode      = desc_i.flush ? MODE_FLUSH : MODE_LOOKUP;
  assign tag_if.index     = desc_index(desc_i);
  assign tag_if.tag       = desc_i.word.lookup.tag;
  // lookups search all ways, flushes name one
  assign tag_if.way       = desc_i.flush ? desc_i.word.flush.way : '1;
  assign tag_if.dirty     = desc_i.rw;

  always_ff @(posedge clk_i) begin
    if (rst_i) held_q <= 1'b0;
    else if (accept) held_q <= 1'b1;
    else if (send) held_q <= 1'b0;
  end

  always_ff @(posedge clk_i) begin
    if (accept) desc_q <= desc_i;
    if (tag_if.res_valid) res_q <= tag_if.res;
  end

  // result is live in the first held cycle, then from the register
  assign res_cur = tag_if.res_valid ? tag_if.res : res_q;

  ////////////////////////////////////////////////////////////////////////////
  // channel steering
  ////////////////////////////////////////////////////////////////////////////
  assign is_flush = desc_q.flush;
  // hits of an id with misses in flight stay behind them
  assign to_hit   = ~is_flush & res_cur.hit & ~to_miss;
  assign blocked  = locked | (~is_flush & stall);
  assign cred_avail = to_hit ? (cred_q[0] != '0) : (cred_q[1] != '0);
  assign send     = held_q & ~blocked & cred_avail;

  assign hit_valid_o  = send & to_hit;
  assign miss_valid_o = send & ~to_hit;

  assign out_id_o    = desc_q.id;
  assign out_rw_o    = desc_q.rw;
  assign out_flush_o = is_flush;
  assign out_index_o = desc_index(desc_q);
  assign out_tag_o   = is_flush ? res_cur.evict_tag : desc_q.word.lookup.tag;
  assign out_way_o   = res_cur.way;
  // forced hits go out with refill clear
  assign refill_o    = ~is_flush & ~res_cur.hit;
  assign evict_o     = res_cur.evict;
  assign evict_tag_o = res_cur.evict_tag;

  // lookups lock their line on the way out
  assign lock_req = send & ~is_flush;
  assign cnt_up   = miss_valid_o & ~is_flush;

  // credit counters
  assign cred_ret   = {miss_credit_i, hit_credit_i};
  assign cred_spend = {miss_valid_o, hit_valid_o};

  always_ff @(posedge clk_i) begin
    for (int c = 0; c < 2; c++) begin
      if (rst_i) begin
        cred_q[c] <= CRED_W'(`LLC_CREDITS);
      end else begin
        cred_q[c] <= cred_q[c] + CRED_W'(cred_ret[c]) - CRED_W'(cred_spend[c]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // submodules
  ////////////////////////////////////////////////////////////////////////////
  llc_way_cfg i_way_cfg (
    .clk_i        ( clk_i        ),
    .rst_i        ( rst_i        ),
    .cfg_we_i     ( cfg_we_i     ),
    .cfg_way_en_i ( cfg_way_en_i ),
    .way_en_o     ( way_en       )
  );

  llc_tag_store i_tag_store (
    .clk_i    ( clk_i  ),
    .rst_i    ( rst_i  ),
    .tag_if   ( tag_if ),
    .way_en_i ( way_en )
  );

  llc_lock_table i_lock_table (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .chk_index_i    ( out_index_o    ),
    .chk_way_i      ( res_cur.way    ),
    .locked_o       ( locked         ),
    .lock_req_i     ( lock_req       ),
    .unlock_valid_i ( unlock_valid_i ),
    .unlock_index_i ( unlock_index_i ),
    .unlock_way_i   ( unlock_way_i   )
  );

  llc_miss_counters i_miss_counters (
    .clk_i        ( clk_i            ),
    .rst_i        ( rst_i            ),
    .up_valid_i   ( cnt_up           ),
    .up_id_i      ( desc_q.id        ),
    .down_valid_i ( cnt_down_valid_i ),
    .down_id_i    ( cnt_down_id_i    ),
    .chk_id_i     ( desc_q.id        ),
    .to_miss_o    ( to_miss          ),
    .stall_o      ( stall            )
  );

endmodule

`default_nettype wire

/* rtl/llc_miss_counters.sv */
`timescale 1ns/1ps
`default_nettype none
`include "llc_defs.svh"

module llc_miss_counters (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              up_valid_i,
  input  llc_desc_pkg::id_t up_id_i,
  input  logic              down_valid_i,
  input  llc_desc_pkg::id_t down_id_i,
  input  llc_desc_pkg::id_t chk_id_i,
  output logic              to_miss_o,
  output logic              stall_o
);
  import llc_desc_pkg::*;

  localparam int NUM_IDS = 2 ** `LLC_ID_W;

  // misses in flight per id
  logic [`LLC_CNT_W-1:0] cnt_q [NUM_IDS];

  // any outstanding miss forces the id onto the miss channel
  assign to_miss_o = cnt_q[chk_id_i] != '0;
  // saturated counter, no further miss may leave
  assign stall_o   = &cnt_q[chk_id_i];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_IDS; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_IDS; i++) begin
        // up and down together cancel
        if (up_valid_i && up_id_i == id_t'(i) &&
            !(down_valid_i && down_id_i == id_t'(i))) begin
          if (!(&cnt_q[i])) cnt_q[i] <= cnt_q[i] + 1'b1;
        end else if (down_valid_i && down_id_i == id_t'(i) &&
                     !(up_valid_i && up_id_i == id_t'(i))) begin
          if (cnt_q[i] != '0) cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/llc_lock_table.sv */
`timescale 1ns/1ps
`default_nettype none
`include "llc_defs.svh"

module llc_lock_table (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  llc_desc_pkg::index_t   chk_index_i,
  input  llc_desc_pkg::way_ind_t chk_way_i,
  output logic                   locked_o,
  input  logic                   lock_req_i,
  input  logic                   unlock_valid_i,
  input  llc_desc_pkg::index_t   unlock_index_i,
  input  llc_desc_pkg::way_ind_t unlock_way_i
);
  import llc_desc_pkg::*;

  // one lock bit per set and way
  way_ind_t lock_q [`LLC_SETS];

  // checked line is busy downstream
  assign locked_o = |(lock_q[chk_index_i] & chk_way_i);

  // unlock first, a lock on the same line wins
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int s = 0; s < `LLC_SETS; s++) begin
        lock_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < `LLC_SETS; s++) begin
        if (unlock_valid_i && unlock_index_i == index_t'(s)) begin
          if (lock_req_i && chk_index_i == index_t'(s)) begin
            lock_q[s] <= (lock_q[s] & ~unlock_way_i) | chk_way_i;
          end else begin
            lock_q[s] <= lock_q[s] & ~unlock_way_i;
          end
        end else if (lock_req_i && chk_index_i == index_t'(s)) begin
          lock_q[s] <= lock_q[s] | chk_way_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/llc_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none
`include "llc_defs.svh"

module llc_tag_store (
  input  logic                   clk_i,
  input  logic                   rst_i,
  llc_tag_if.store               tag_if,
  input  llc_desc_pkg::way_ind_t way_en_i
);
  import llc_desc_pkg::*;
  import llc_store_pkg::*;

  localparam int WAY_IW = $clog2(`LLC_WAYS);

  // tag array and per-set round robin pointer
  tag_entry_t        tags_q [`LLC_SETS][`LLC_WAYS];
  logic [WAY_IW-1:0] rr_q   [`LLC_SETS];

  // clear walk, one set per cycle
  logic   clr_busy_q;
  index_t clr_idx_q;

  logic              take;
  store_mode_e       eff_mode;
  index_t            eff_index;
  way_ind_t          cand, hit_vec, free_vec;
  logic              hit, free_any, any_en, wr_en;
  logic [WAY_IW-1:0] hit_idx, free_idx, flush_idx, rr_idx, rr_cand, sel_idx;
  tag_entry_t        sel_ent, new_ent;
  store_res_t        res_d, res_q;
  logic              res_valid_q;

  assign take = tag_if.req_valid & tag_if.req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // lookup and victim selection
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    // disabled ways neither hit nor get chosen
    cand     = way_en_i & tag_if.way;
    hit_vec  = '0;
    free_vec = '0;
    for (int w = 0; w < `LLC_WAYS; w++) begin
      hit_vec[w]  = cand[w] & tags_q[tag_if.index][w].valid &
                    (tags_q[tag_if.index][w].tag == tag_if.tag);
      free_vec[w] = cand[w] & ~tags_q[tag_if.index][w].valid;
    end
    hit      = |hit_vec;
    free_any = |free_vec;
    any_en   = |cand;

    // priority encoders, lowest way wins
    hit_idx   = '0;
    free_idx  = '0;
    flush_idx = '0;
    for (int w = `LLC_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) hit_idx = WAY_IW'(w);
      if (free_vec[w]) free_idx = WAY_IW'(w);
      if (tag_if.way[w]) flush_idx = WAY_IW'(w);
    end

    // first enabled way at or after the set's pointer
    rr_idx  = rr_q[tag_if.index];
    rr_cand = '0;
    for (int k = `LLC_WAYS - 1; k >= 0; k--) begin
      rr_cand = rr_q[tag_if.index] + WAY_IW'(k);
      if (cand[rr_cand]) rr_idx = rr_cand;
    end

    if (tag_if.mode == MODE_FLUSH) sel_idx = flush_idx;
    else if (hit) sel_idx = hit_idx;
    else if (free_any) sel_idx = free_idx;
    else sel_idx = rr_idx;
    sel_ent = tags_q[tag_if.index][sel_idx];

    res_d   = '0;
    new_ent = '0;
    wr_en   = 1'b0;
    case (tag_if.mode)
      MODE_LOOKUP: begin
        res_d.way       = any_en ? (way_ind_t'(1'b1) << sel_idx) : '0;
        res_d.hit       = hit;
        res_d.evict     = ~hit & any_en & sel_ent.valid & sel_ent.dirty;
        res_d.evict_tag = sel_ent.tag;
        new_ent.valid   = 1'b1;
        new_ent.tag     = tag_if.tag;
        // a hit keeps its dirty state, a refilled line starts from rw
        new_ent.dirty   = (hit & sel_ent.dirty) | tag_if.dirty;
        wr_en           = any_en;
      end
      MODE_FLUSH: begin
        res_d.way       = tag_if.way;
        res_d.evict     = (|tag_if.way) & sel_ent.valid & sel_ent.dirty;
        res_d.evict_tag = sel_ent.tag;
        // new_ent stays zero, the line is invalidated
        wr_en           = |tag_if.way;
      end
      default: begin
        // clear request, whole set dropped below
        wr_en = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // array update, shared by the clear walk and requests
  ////////////////////////////////////////////////////////////////////////////
  assign eff_mode  = clr_busy_q ? MODE_CLEAR : tag_if.mode;
  assign eff_index = clr_busy_q ? clr_idx_q : tag_if.index;

  always_ff @(posedge clk_i) begin
    if (clr_busy_q || take) begin
      if (eff_mode == MODE_CLEAR) begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
          tags_q[eff_index][w] <= '0;
        end
        rr_q[eff_index] <= '0;
      end else if (wr_en) begin
        tags_q[eff_index][sel_idx] <= new_ent;
        // every lookup miss moves the pointer past its current way
        if (eff_mode == MODE_LOOKUP && !hit) begin
          rr_q[eff_index] <= rr_idx + WAY_IW'(1);
        end
      end
    end
  end

  // walk starts right out of reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      clr_busy_q  <= 1'b1;
      clr_idx_q   <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= take;
      if (clr_busy_q) begin
        clr_idx_q <= clr_idx_q + 1'b1;
        if (clr_idx_q == index_t'(`LLC_SETS - 1)) clr_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) res_q <= res_d;
  end

  assign tag_if.req_ready = ~clr_busy_q;
  assign tag_if.res_valid = res_valid_q;
  assign tag_if.res       = res_q;

endmodule

`default_nettype wire

/* rtl/llc_way_cfg.sv */
`timescale 1ns/1ps
`default_nettype none

module llc_way_cfg (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cfg_we_i,
  input  llc_desc_pkg::way_ind_t cfg_way_en_i,
  output llc_desc_pkg::way_ind_t way_en_o
);
  import llc_desc_pkg::*;

  // enable mask, one bit per way
  way_ind_t way_en_q;

  // all ways usable after reset
  // a write lands at the next edge
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      way_en_q <= '1;
    end else if (cfg_we_i) begin
      way_en_q <= cfg_way_en_i;
    end
  end

  assign way_en_o = way_en_q;

endmodule

`default_nettype wire

/* rtl/llc_tag_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface llc_tag_if;
  import llc_desc_pkg::*;
  import llc_store_pkg::*;

  // request, taken on req_valid and req_ready
  logic        req_valid;
  logic        req_ready;
  store_mode_e mode;
  index_t      index;
  tag_t        tag;
  // candidate ways for a lookup, named way for a flush
  way_ind_t    way;
  logic        dirty;

  // result, one cycle after the request
  logic        res_valid;
  store_res_t  res;

  modport ctrl (
    output req_valid, mode, index, tag, way, dirty,
    input  req_ready, res_valid, res
  );

  modport store (
    input  req_valid, mode, index, tag, way, dirty,
    output req_ready, res_valid, res
  );

endinterface

`default_nettype wire

/* rtl/llc_store_pkg.sv */
`default_nettype none
`include "llc_defs.svh"

package llc_store_pkg;

  // operation requested from the tag store
  typedef enum logic [1:0] {
    MODE_CLEAR  = 2'd0,
    MODE_LOOKUP = 2'd1,
    MODE_FLUSH  = 2'd2
  } store_mode_e;

  // one line of the tag array
  typedef struct packed {
    logic               valid;
    logic               dirty;
    llc_desc_pkg::tag_t tag;
  } tag_entry_t;

  // lookup or flush result
  typedef struct packed {
    llc_desc_pkg::way_ind_t way;
    logic                   hit;
    logic                   evict;
    llc_desc_pkg::tag_t     evict_tag;
  } store_res_t;

endpackage

`default_nettype wire

/* rtl/llc_desc_pkg.sv */
`default_nettype none
`include "llc_defs.svh"

package llc_desc_pkg;

  // one-hot way indicator
  typedef logic [`LLC_WAYS-1:0]    way_ind_t;
  typedef logic [`LLC_INDEX_W-1:0] index_t;
  typedef logic [`LLC_TAG_W-1:0]   tag_t;
  typedef logic [`LLC_ID_W-1:0]    id_t;

  // lookup view: tag above the set index
  typedef struct packed {
    tag_t   tag;
    index_t index;
  } lookup_fields_t;

  // flush view: named way, set index, spare low bits
  typedef struct packed {
    way_ind_t                        way;
    index_t                          index;
    logic [`LLC_TAG_W-`LLC_WAYS-1:0] spare;
  } flush_fields_t;

  // same 12 bit word, decoded by the flush bit
  typedef union packed {
    lookup_fields_t lookup;
    flush_fields_t  flush;
  } desc_word_u;

  typedef struct packed {
    logic       flush;
    logic       rw;
    id_t        id;
    desc_word_u word;
  } desc_t;

endpackage

`default_nettype wire

/* rtl/llc_defs.svh */
`ifndef LLC_DEFS_SVH
`define LLC_DEFS_SVH

// cache geometry
`define LLC_WAYS    4
`define LLC_SETS    16
`define LLC_INDEX_W 4
`define LLC_TAG_W   8

// descriptor id space, 4 ids
`define LLC_ID_W    2

// per-id miss counter, saturated value means stall
`define LLC_CNT_W   2

// credits per output channel after reset
`define LLC_CREDITS 2

`endif
